/* dv/hazard_props.sv */
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module hazardProps (
	input logic              clk,
	input logic              rstN,
	input logic              stallD,
	input logic              stallE,
	input logic              flushE,
	input logic              flushM,
	input logic              divBusyE,
	input logic              forwardAD,
	input logic              forwardBD,
	input logic [1:0]        forwardAE,
	input logic [1:0]        forwardBE,
	input logic [`REG_W-1:0] rsD,
	input logic [`REG_W-1:0] rtD,
	input logic [`REG_W-1:0] rsE,
	input logic [`REG_W-1:0] rtE
);
	// front stall without the divider means a bubble into execute
	stallBubble: assert property (@(posedge clk) disable iff (!rstN)
		(stallD && !divBusyE) |-> flushE) else $error("decode stall without execute bubble");

	// divider freeze holds execute and drains memory
	divFreeze: assert property (@(posedge clk) disable iff (!rstN)
		divBusyE |-> (stallE && flushM && !flushE)) else $error("divider freeze malformed");

	// r0 is never a forward source
	fwdZeroE: assert property (@(posedge clk) disable iff (!rstN)
		((forwardAE == `FWD_REG) || (rsE != '0)) && ((forwardBE == `FWD_REG) || (rtE != '0)))
		else $error("execute forward from r0");
	fwdZeroD: assert property (@(posedge clk) disable iff (!rstN)
		(!forwardAD || (rsD != '0)) && (!forwardBD || (rtD != '0)))
		else $error("decode forward from r0");
endmodule

/* dv/tb.sv */
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module tb;
	import mipsPkg::*;

	logic              clk;
	logic              rstN;
	logic [`XLEN-1:0]  instrAddr, instr, dataAddr, dataWData, dataRData, wbData;
	logic              memWrite, wbValid;
	logic [`REG_W-1:0] wbReg;

	// rom and ram live here, both read combinationally
	logic [`XLEN-1:0] rom [1024];
	logic [`XLEN-1:0] ram [256];
	int               progLen;
	// expected retire stream, kind 0 is a register write and 1 a store
	bit               expKind [$];
	logic [`XLEN-1:0] expA [$];
	logic [`XLEN-1:0] expD [$];
	string            curTest;
	int               errCount, passCount, failCount;

	assign instr     = rom[instrAddr[11:2]];
	assign dataRData = ram[dataAddr[9:2]];

	mipsCore dut_i (.*);

	bind hazardUnit hazardProps props_i (
		.clk(tb.clk), .rstN(tb.rstN), .stallD(hz.stallD), .stallE(hz.stallE),
		.flushE(hz.flushE), .flushM(hz.flushM), .divBusyE(hz.divBusyE),
		.forwardAD(hz.forwardAD), .forwardBD(hz.forwardBD), .forwardAE(hz.forwardAE),
		.forwardBE(hz.forwardBE), .rsD(hz.rsD), .rtD(hz.rtD), .rsE(hz.rsE), .rtE(hz.rtE)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ram contents before any store, spread over every address bit
	function automatic logic [`XLEN-1:0] fillWord(input logic [`XLEN-1:0] a);
		return (a * 32'h9E3779B1) ^ {a[15:0], ~a[15:0]};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// architectural model
	//////////////////////////////////////////////////////////////////////

	// sequential run with one delay slot, fills the expected stream
	function automatic void runModel(input int nWords);
		logic [`XLEN-1:0] r [32];
		logic [`XLEN-1:0] m [256];
		logic [`XLEN-1:0] pc, npc, nn, a, b, imm, v;
		logic [`REG_W-1:0] dst;
		logic             wr;
		instrT            w;
		int               steps;
		for (int i = 0; i < 32; i++) r[i] = '0;
		for (int i = 0; i < 256; i++) m[i] = fillWord(32'(i * 4));
		pc = '0;
		npc = 32'd4;
		steps = 0;
		while (pc < 32'(nWords * 4) && steps < 4000) begin
			w = rom[pc[11:2]];
			nn = npc + 32'd4;
			a = r[w.rType.rs];
			b = r[w.rType.rt];
			imm = {{16{w.iType.imm[15]}}, w.iType.imm};
			wr = 1'b0;
			dst = w.iType.rt;
			v = '0;
			case (w.rType.opcode)
				`OP_RTYPE: begin
					wr = 1'b1;
					dst = w.rType.rd;
					case (w.rType.funct)
						`FN_ADD: v = a + b;
						`FN_SUB: v = a - b;
						`FN_AND: v = a & b;
						`FN_OR:  v = a | b;
						`FN_SLT: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						// zero divisor yields all ones
						`FN_DIV: v = (b == '0) ? '1 : a / b;
						default: wr = 1'b0;
					endcase
				end
				`OP_ADDI: begin
					wr = 1'b1;
					v = a + imm;
				end
				`OP_LW: begin
					wr = 1'b1;
					v = m[(a + imm) >> 2 & 32'hff];
				end
				`OP_SW: begin
					expKind.push_back(1'b1);
					expA.push_back(a + imm);
					expD.push_back(b);
					m[(a + imm) >> 2 & 32'hff] = b;
				end
				// target is relative to the delay slot
				`OP_BEQ: if (a == b) nn = pc + 32'd4 + (imm << 2);
				default: ;
			endcase
			if (wr && dst != '0) begin
				r[dst] = v;
				expKind.push_back(1'b0);
				expA.push_back(32'(dst));
				expD.push_back(v);
			end
			pc = npc;
			npc = nn;
			steps++;
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// comparator
	//////////////////////////////////////////////////////////////////////

	task automatic checkEvent(input bit kind, input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] d);
		bit               k;
		logic [`XLEN-1:0] ea, ed;
		if (expKind.size() == 0) begin
			$display("%s: unexpected %s with no write left in the model", curTest,
				kind ? "store" : "register write");
			errCount++;
		end else begin
			k = expKind.pop_front();
			ea = expA.pop_front();
			ed = expD.pop_front();
			if (k != kind || ea !== a || ed !== d) begin
				$display("MISMATCH %s expected %s %h=%h actual %s %h=%h", curTest,
					k ? "store" : "reg", ea, ed, kind ? "store" : "reg", a, d);
				errCount++;
			end
		end
	endtask

	// write-back is older than the store in memory, so it goes first
	always @(posedge clk) begin
		if (rstN) begin
			if (wbValid) checkEvent(1'b0, 32'(wbReg), wbData);
			if (memWrite) begin
				checkEvent(1'b1, dataAddr, dataWData);
				ram[dataAddr[9:2]] <= dataWData;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// assembler and test flow
	//////////////////////////////////////////////////////////////////////

	task automatic emitR(input logic [5:0] fn, input logic [4:0] rd, rs, rt);
		rom[progLen] = {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
		progLen++;
	endtask

	task automatic emitI(input logic [5:0] op, input logic [4:0] rt, rs, input logic [15:0] imm);
		rom[progLen] = {op, rs, rt, imm};
		progLen++;
	endtask

	task automatic emitRandAlu();
		logic [5:0] fns [5];
		int         k;
		fns = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT};
		k = $urandom_range(0, 5);
		if (k == 5) begin
			emitI(`OP_ADDI, 5'($urandom_range(0, 6)), 5'($urandom_range(0, 6)), 16'($urandom));
		end else begin
			emitR(fns[k], 5'($urandom_range(0, 6)), 5'($urandom_range(0, 6)),
				5'($urandom_range(0, 6)));
		end
	endtask

	// reset is held while the program is rewritten
	task automatic startTest(input string name);
		@(negedge clk);
		rstN = 1'b0;
		curTest = name;
		progLen = 0;
		for (int i = 0; i < 1024; i++) rom[i] = '0;
	endtask

	task automatic finishTest();
		int cycles;
		int errsBefore;
		errsBefore = errCount;
		for (int i = 0; i < 256; i++) ram[i] = fillWord(32'(i * 4));
		runModel(progLen);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			if (wbValid !== 1'b0 || memWrite !== 1'b0 || instrAddr !== '0) begin
				$display("%s: outputs active or pc nonzero during reset", curTest);
				errCount++;
			end
		end
		@(negedge clk);
		rstN = 1'b1;
		@(posedge clk);
		if (instrAddr !== '0) begin
			$display("MISMATCH %s expected pc %h actual %h", curTest, 32'd0, instrAddr);
			errCount++;
		end
		cycles = 0;
		while (expKind.size() > 0 && cycles < 6000) begin
			@(posedge clk);
			cycles++;
		end
		if (expKind.size() > 0) begin
			$display("%s: timed out with %0d writes still expected", curTest, expKind.size());
			errCount++;
			expKind.delete();
			expA.delete();
			expD.delete();
		end
		// trailing window catches duplicated writes
		repeat (12) @(posedge clk);
		if (errCount == errsBefore) begin
			passCount++;
			$display("test %s done: ok", curTest);
		end else begin
			failCount++;
			$display("test %s done: %0d errors", curTest, errCount - errsBefore);
		end
	endtask

	initial begin
		logic [15:0] v;
		logic [15:0] off;
		rstN = 1'b0;
		errCount = 0;
		passCount = 0;
		failCount = 0;
		progLen = 0;
		// memories defined before the first fetch
		for (int i = 0; i < 1024; i++) rom[i] = '0;
		for (int i = 0; i < 256; i++) ram[i] = fillWord(32'(i * 4));
		void'($urandom(82725));

		startTest("reset");
		finishTest();

		startTest("forwarding");
		for (int i = 1; i <= 6; i++) emitI(`OP_ADDI, 5'(i), 5'd0, 16'($urandom));
		for (int i = 0; i < 40; i++) emitRandAlu();
		finishTest();

		startTest("loadUse");
		for (int i = 0; i < 6; i++) begin
			off = 16'(64 + i * 8);
			emitI(`OP_ADDI, 5'd1, 5'd0, 16'($urandom));
			emitI(`OP_SW, 5'd1, 5'd0, off);
			emitI(`OP_LW, 5'd2, 5'd0, off);
			emitR(`FN_ADD, 5'd3, 5'd2, 5'd1);
			emitI(`OP_LW, 5'd4, 5'd0, off + 16'd4);
			// store straight after the load it uses
			emitI(`OP_SW, 5'd4, 5'd0, off + 16'd400);
			emitR(`FN_OR, 5'd5, 5'd4, 5'd3);
		end
		finishTest();

		startTest("branch");
		for (int i = 0; i < 10; i++) begin
			v = 16'($urandom);
			emitI(`OP_ADDI, 5'd1, 5'd0, v);
			emitI(`OP_ADDI, 5'd2, 5'd0, $urandom_range(0, 1) ? v : v + 16'd1);
			if (i % 2 == 1) begin
				emitI(`OP_SW, 5'd2, 5'd0, 16'd512);
				emitI(`OP_LW, 5'd2, 5'd0, 16'd512);
			end
			emitI(`OP_BEQ, 5'd2, 5'd1, 16'd2);
			// delay slot, then the skipped slot
			emitI(`OP_ADDI, 5'd3, 5'd3, 16'd1);
			emitI(`OP_ADDI, 5'd4, 5'd4, 16'd1);
			emitI(`OP_ADDI, 5'd5, 5'd5, 16'd1);
		end
		finishTest();

		startTest("divide");
		for (int i = 0; i < 6; i++) begin
			emitI(`OP_LW, 5'd1, 5'd0, 16'($urandom_range(0, 63) * 4));
			if (i % 2 == 0) emitI(`OP_ADDI, 5'd2, 5'd0, 16'($urandom_range(1, 255)));
			else emitI(`OP_LW, 5'd2, 5'd0, 16'($urandom_range(0, 63) * 4));
			emitR(`FN_DIV, 5'd3, 5'd1, (i % 3 == 0) ? 5'd0 : 5'd2);
			emitR(`FN_ADD, 5'd4, 5'd3, 5'd1);
			emitR(`FN_DIV, 5'd5, 5'd3, 5'd2);
			emitI(`OP_SW, 5'd5, 5'd0, 16'(800 + i * 4));
		end
		finishTest();

		$display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
		if (errCount == 0 && failCount == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end
endmodule

/* list.f */
+incdir+rtl
rtl/mipsPkg.sv
rtl/hazardIf.sv
rtl/hazardUnit.sv
rtl/regFile.sv
rtl/ctrlDecoder.sv
rtl/divUnit.sv
rtl/mipsCore.sv
dv/hazard_props.sv
dv/tb.sv

/* rtl/ctrlDecoder.sv */
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module ctrlDecoder (
	input  mipsPkg::instrT    instr,
	output logic              regWrite,
	output logic              memToReg,
	output logic              memWrite,
	output logic              aluSrcImm,
	output logic              branch,
	output logic              isDiv,
	output logic [2:0]        aluOp,
	output logic [`REG_W-1:0] writeReg
);
	always_comb begin
		// defaults give a bubble
		regWrite  = 1'b0;
		memToReg  = 1'b0;
		memWrite  = 1'b0;
		aluSrcImm = 1'b0;
		branch    = 1'b0;
		isDiv     = 1'b0;
		aluOp     = `ALU_ADD;
		// i-type target is rt
		writeReg  = instr.iType.rt;
		// opcode field overlays in both views
		case (instr.rType.opcode)
			`OP_RTYPE: begin
				writeReg = instr.rType.rd;
				regWrite = 1'b1;
				case (instr.rType.funct)
					`FN_ADD: aluOp = `ALU_ADD;
					`FN_SUB: aluOp = `ALU_SUB;
					`FN_AND: aluOp = `ALU_AND;
					`FN_OR:  aluOp = `ALU_OR;
					`FN_SLT: aluOp = `ALU_SLT;
					`FN_DIV: isDiv = 1'b1;
					// unknown funct retires nothing
					default: regWrite = 1'b0;
				endcase
			end
			`OP_ADDI: begin
				regWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			`OP_LW: begin
				regWrite  = 1'b1;
				memToReg  = 1'b1;
				aluSrcImm = 1'b1;
			end
			`OP_SW: begin
				memWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			`OP_BEQ: branch = 1'b1;
			default: ;
		endcase
	end
endmodule

/* rtl/divUnit.sv */
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module divUnit (
	input  logic             clk,
	input  logic             rstN,
	input  logic             start,
	input  logic [`XLEN-1:0] dividend,
	input  logic [`XLEN-1:0] divisor,
	output logic             busy,
	output logic             done,
	output logic [`XLEN-1:0] quotient
);
	localparam int CNT_W = $clog2(`DIV_CYCLES);

	logic [CNT_W-1:0] count;
	logic [`XLEN-1:0] remR;
	logic [`XLEN-1:0] quoR;
	logic [`XLEN-1:0] divR;
	logic [`XLEN:0]   trial;
	logic             fits;

	// partial remainder shifted left with next dividend bit
	assign trial = {remR, quoR[`XLEN-1]};
	// zero divisor always fits so every bit comes out one
	assign fits  = trial >= {1'b0, divR};
	// dividend bits leave the top as quotient bits enter the bottom
	assign quotient = quoR;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else begin
			done <= 1'b0;
			if (start && !busy) begin
				busy  <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				// last step, quotient valid with done
				if (count == CNT_W'(`DIV_CYCLES - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// restoring step
	always_ff @(posedge clk) begin
		if (start && !busy) begin
			remR <= '0;
			quoR <= dividend;
			divR <= divisor;
		end else if (busy) begin
			remR <= fits ? (trial[`XLEN-1:0] - divR) : trial[`XLEN-1:0];
			quoR <= {quoR[`XLEN-2:0], fits};
		end
	end
endmodule

/* rtl/hazardIf.sv */
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

interface hazardIf;
	// decode stage
	logic [`REG_W-1:0] rsD;
	logic [`REG_W-1:0] rtD;
	logic              branchD;
	// execute stage
	logic [`REG_W-1:0] rsE;
	logic [`REG_W-1:0] rtE;
	logic [`REG_W-1:0] writeRegE;
	logic              regWriteE;
	logic              memToRegE;
	logic              divBusyE;
	// memory and write-back stages
	logic [`REG_W-1:0] writeRegM;
	logic              regWriteM;
	logic              memToRegM;
	logic [`REG_W-1:0] writeRegW;
	logic              regWriteW;
	// back toward the pipe
	logic              stallF;
	logic              stallD;
	logic              stallE;
	logic              flushE;
	logic              flushM;
	logic              forwardAD;
	logic              forwardBD;
	logic [1:0]        forwardAE;
	logic [1:0]        forwardBE;

	modport core (
		output rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE, divBusyE,
		output writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		input  stallF, stallD, stallE, flushE, flushM,
		input  forwardAD, forwardBD, forwardAE, forwardBE
	);

	modport unit (
		input  rsD, rtD, branchD, rsE, rtE, writeRegE, regWriteE, memToRegE, divBusyE,
		input  writeRegM, regWriteM, memToRegM, writeRegW, regWriteW,
		output stallF, stallD, stallE, flushE, flushM,
		output forwardAD, forwardBD, forwardAE, forwardBE
	);
endinterface

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module hazardUnit (
	hazardIf.unit hz
);
	logic lwStall;
	logic branchStall;
	logic frontStall;

	// operand source for execute
	// memory result is newer than write-back so it wins
	function automatic logic [1:0] fwdSelE(
		input logic [`REG_W-1:0] src,
		input logic [`REG_W-1:0] wrM,
		input logic              weM,
		input logic [`REG_W-1:0] wrW,
		input logic              weW
	);
		if (src == '0) begin
			return `FWD_REG;
		end else if (weM && src == wrM) begin
			return `FWD_M;
		end else if (weW && src == wrW) begin
			return `FWD_W;
		end
		return `FWD_REG;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// forwarding
	//////////////////////////////////////////////////////////////////////

	assign hz.forwardAE = fwdSelE(hz.rsE, hz.writeRegM, hz.regWriteM, hz.writeRegW, hz.regWriteW);
	assign hz.forwardBE = fwdSelE(hz.rtE, hz.writeRegM, hz.regWriteM, hz.writeRegW, hz.regWriteW);

	// branch comparator only taps the memory stage
	// older results already sit in the register file
	assign hz.forwardAD = (hz.rsD != '0) && hz.regWriteM && (hz.rsD == hz.writeRegM);
	assign hz.forwardBD = (hz.rtD != '0) && hz.regWriteM && (hz.rtD == hz.writeRegM);

	//////////////////////////////////////////////////////////////////////
	// stalls
	//////////////////////////////////////////////////////////////////////

	// load data shows up one stage too late for the next instruction
	assign lwStall = hz.memToRegE && (hz.rtE == hz.rsD || hz.rtE == hz.rtD);

	// compare in decode needs values that do not exist yet
	assign branchStall = hz.branchD &&
		((hz.regWriteE && (hz.writeRegE == hz.rsD || hz.writeRegE == hz.rtD)) ||
		 (hz.memToRegM && (hz.writeRegM == hz.rsD || hz.writeRegM == hz.rtD)));

	assign frontStall = lwStall || branchStall || hz.divBusyE;

	assign hz.stallF = frontStall;
	assign hz.stallD = frontStall;

	// divider freeze holds execute too and drains the memory slot
	assign hz.stallE = hz.divBusyE;
	assign hz.flushM = hz.divBusyE;
	// bubble into execute only when execute itself moves
	assign hz.flushE = (lwStall || branchStall) && !hz.divBusyE;
endmodule

/* rtl/mipsCore.sv */
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module mipsCore (
	input  logic              clk,
	input  logic              rstN,
	output logic [`XLEN-1:0]  instrAddr,
	input  logic [`XLEN-1:0]  instr,
	output logic [`XLEN-1:0]  dataAddr,
	output logic [`XLEN-1:0]  dataWData,
	output logic              memWrite,
	input  logic [`XLEN-1:0]  dataRData,
	output logic              wbValid,
	output logic [`REG_W-1:0] wbReg,
	output logic [`XLEN-1:0]  wbData
);
	import mipsPkg::*;

	// fetch
	logic [`XLEN-1:0] pcF, pcPlus4F, pcNextF;
	// decode
	instrT             instrD;
	logic [`XLEN-1:0]  pcPlus4D, rd1D, rd2D, signImmD, pcBranchD, eqAD, eqBD;
	logic              regWriteD, memToRegD, memWriteD, aluSrcImmD, branchD, isDivD, pcSrcD;
	logic [2:0]        aluOpD;
	logic [`REG_W-1:0] writeRegD;
	// execute
	logic              regWriteE, memToRegE, memWriteE, aluSrcImmE, isDivE;
	logic [2:0]        aluOpE;
	logic [`REG_W-1:0] rsE, rtE, writeRegE;
	logic [`XLEN-1:0]  rd1E, rd2E, signImmE, srcAE, srcBE, writeDataE, aluResE, resultE;
	logic              divStart, divBusy, divDone;
	logic [`XLEN-1:0]  quotient;
	// memory
	logic              regWriteM, memToRegM, memWriteM;
	logic [`REG_W-1:0] writeRegM;
	logic [`XLEN-1:0]  aluOutM, writeDataM;
	// write-back
	logic              regWriteW, memToRegW;
	logic [`REG_W-1:0] writeRegW;
	logic [`XLEN-1:0]  aluOutW, readDataW, resultW;

	hazardIf hz ();

	hazardUnit hazard_i (.hz(hz.unit));

	function automatic logic [`XLEN-1:0] fwdMux(
		input logic [1:0]       sel,
		input logic [`XLEN-1:0] regVal,
		input logic [`XLEN-1:0] memVal,
		input logic [`XLEN-1:0] wbVal
	);
		case (sel)
			`FWD_M:  return memVal;
			`FWD_W:  return wbVal;
			default: return regVal;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// fetch
	//////////////////////////////////////////////////////////////////////

	assign pcPlus4F  = pcF + `XLEN'(4);
	// branch in decode redirects after the delay slot
	assign pcNextF   = pcSrcD ? pcBranchD : pcPlus4F;
	assign instrAddr = pcF;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcF    <= '0;
			instrD <= '0;
		end else if (!hz.stallF) begin
			pcF    <= pcNextF;
			instrD <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!hz.stallD) begin
			pcPlus4D <= pcPlus4F;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////

	ctrlDecoder dec_i (
		.instr(instrD), .regWrite(regWriteD), .memToReg(memToRegD), .memWrite(memWriteD),
		.aluSrcImm(aluSrcImmD), .branch(branchD), .isDiv(isDivD), .aluOp(aluOpD),
		.writeReg(writeRegD)
	);

	regFile rf_i (
		.clk, .rstN, .ra1(instrD.rType.rs), .ra2(instrD.rType.rt), .rd1(rd1D), .rd2(rd2D),
		.we(regWriteW), .wa(writeRegW), .wd(resultW)
	);

	assign signImmD  = {{(`XLEN-16){instrD.iType.imm[15]}}, instrD.iType.imm};
	assign pcBranchD = pcPlus4D + {signImmD[`XLEN-3:0], 2'b00};
	// equality compare with memory bypass
	assign eqAD      = hz.forwardAD ? aluOutM : rd1D;
	assign eqBD      = hz.forwardBD ? aluOutM : rd2D;
	assign pcSrcD    = branchD && (eqAD == eqBD);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{regWriteE, memToRegE, memWriteE, aluSrcImmE, isDivE} <= '0;
			{aluOpE, writeRegE, rsE, rtE} <= '0;
		end else if (hz.flushE) begin
			// bubble
			{regWriteE, memToRegE, memWriteE, aluSrcImmE, isDivE} <= '0;
			{aluOpE, writeRegE, rsE, rtE} <= '0;
		end else if (!hz.stallE) begin
			{regWriteE, memToRegE, memWriteE} <= {regWriteD, memToRegD, memWriteD};
			{aluSrcImmE, isDivE, aluOpE}      <= {aluSrcImmD, isDivD, aluOpD};
			writeRegE <= writeRegD;
			rsE       <= instrD.rType.rs;
			rtE       <= instrD.rType.rt;
		end
	end

	always_ff @(posedge clk) begin
		if (!hz.stallE) begin
			rd1E     <= rd1D;
			rd2E     <= rd2D;
			signImmE <= signImmD;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// execute
	//////////////////////////////////////////////////////////////////////

	assign srcAE      = fwdMux(hz.forwardAE, rd1E, aluOutM, resultW);
	assign writeDataE = fwdMux(hz.forwardBE, rd2E, aluOutM, resultW);
	assign srcBE      = aluSrcImmE ? signImmE : writeDataE;

	always_comb begin
		case (aluOpE)
			`ALU_AND: aluResE = srcAE & srcBE;
			`ALU_OR:  aluResE = srcAE | srcBE;
			`ALU_SUB: aluResE = srcAE - srcBE;
			`ALU_SLT: aluResE = {{(`XLEN-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
			default:  aluResE = srcAE + srcBE;
		endcase
	end

	// one start per div, then hold execute until done
	assign divStart    = isDivE && !divBusy && !divDone;
	assign hz.divBusyE = isDivE && !divDone;
	assign resultE     = isDivE ? quotient : aluResE;

	divUnit div_i (
		.clk, .rstN, .start(divStart), .dividend(srcAE), .divisor(writeDataE),
		.busy(divBusy), .done(divDone), .quotient
	);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{regWriteM, memToRegM, memWriteM, writeRegM} <= '0;
		end else if (hz.flushM) begin
			{regWriteM, memToRegM, memWriteM, writeRegM} <= '0;
		end else begin
			{regWriteM, memToRegM, memWriteM} <= {regWriteE, memToRegE, memWriteE};
			writeRegM <= writeRegE;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM    <= resultE;
		writeDataM <= writeDataE;
	end

	//////////////////////////////////////////////////////////////////////
	// memory and write-back
	//////////////////////////////////////////////////////////////////////

	assign dataAddr  = aluOutM;
	assign dataWData = writeDataM;
	assign memWrite  = memWriteM;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			{regWriteW, memToRegW, writeRegW} <= '0;
		end else begin
			{regWriteW, memToRegW, writeRegW} <= {regWriteM, memToRegM, writeRegM};
		end
	end

	always_ff @(posedge clk) begin
		aluOutW   <= aluOutM;
		readDataW <= dataRData;
	end

	assign resultW = memToRegW ? readDataW : aluOutW;
	// r0 writes retire silently
	assign wbValid = regWriteW && (writeRegW != '0);
	assign wbReg   = writeRegW;
	assign wbData  = resultW;

	// stage info for the hazard unit
	assign hz.rsD       = instrD.rType.rs;
	assign hz.rtD       = instrD.rType.rt;
	assign hz.branchD   = branchD;
	assign hz.rsE       = rsE;
	assign hz.rtE       = rtE;
	assign hz.writeRegE = writeRegE;
	assign hz.regWriteE = regWriteE;
	assign hz.memToRegE = memToRegE;
	assign hz.writeRegM = writeRegM;
	assign hz.regWriteM = regWriteM;
	assign hz.memToRegM = memToRegM;
	assign hz.writeRegW = writeRegW;
	assign hz.regWriteW = regWriteW;
endmodule

/* rtl/mipsCore_cfg.svh */
`ifndef MIPSCORE_CFG_SVH
`define MIPSCORE_CFG_SVH

// data word and register number widths
`define XLEN  32
`define REG_W 5

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b
`define OP_BEQ   6'h04

// funct codes inside the r-type group
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a
`define FN_DIV 6'h1a

// alu operation codes
`define ALU_AND 3'b000
`define ALU_OR  3'b001
`define ALU_ADD 3'b010
`define ALU_SUB 3'b110
`define ALU_SLT 3'b111

// execute operand sources
`define FWD_REG 2'd0
`define FWD_W   2'd1
`define FWD_M   2'd2

// divider stays busy one cycle per quotient bit
`define DIV_CYCLES 32

`endif

/* rtl/mipsPkg.sv */
`include "mipsCore_cfg.svh"

package mipsPkg;

	// one instruction word with two field layouts
	// opcode, rs and rt sit at the same bits in both
	typedef union packed {
		// register form
		struct packed {
			logic [5:0]        opcode;
			logic [`REG_W-1:0] rs;
			logic [`REG_W-1:0] rt;
			logic [`REG_W-1:0] rd;
			logic [4:0]        shamt;
			logic [5:0]        funct;
		} rType;
		// immediate form
		// addi, lw, sw and beq
		struct packed {
			logic [5:0]        opcode;
			logic [`REG_W-1:0] rs;
			logic [`REG_W-1:0] rt;
			logic [15:0]       imm;
		} iType;
	} instrT;

endpackage

/* rtl/regFile.sv */
`timescale 1ns/1ps
`include "mipsCore_cfg.svh"

module regFile (
	input  logic              clk,
	input  logic              rstN,
	input  logic [`REG_W-1:0] ra1,
	input  logic [`REG_W-1:0] ra2,
	output logic [`XLEN-1:0]  rd1,
	output logic [`XLEN-1:0]  rd2,
	input  logic              we,
	input  logic [`REG_W-1:0] wa,
	input  logic [`XLEN-1:0]  wd
);
	logic [`XLEN-1:0] regs [2**`REG_W];

	// write-first so decode sees the value retiring this cycle
	// r0 reads zero whatever sits in the array
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**`REG_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end
endmodule

/* run.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb -f list.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vtb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Simulation passed"; then
	exit 0
fi
exit 1
